//--- source/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [4:0]            aluop_t;
    typedef logic [2:0]            alusel_t;
    typedef logic [2:0]            imm_fmt_t;

    // RV32I major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // SUB and SRA/SRAI

    localparam aluop_t EX_NOP   = 5'd0;
    localparam aluop_t EX_ADD   = 5'd1;
    localparam aluop_t EX_SUB   = 5'd2;
    localparam aluop_t EX_XOR   = 5'd3;
    localparam aluop_t EX_OR    = 5'd4;
    localparam aluop_t EX_AND   = 5'd5;
    localparam aluop_t EX_SLL   = 5'd6;
    localparam aluop_t EX_SRL   = 5'd7;
    localparam aluop_t EX_SRA   = 5'd8;
    localparam aluop_t EX_SLT   = 5'd9;
    localparam aluop_t EX_SLTU  = 5'd10;
    localparam aluop_t EX_LB    = 5'd11;
    localparam aluop_t EX_LH    = 5'd12;
    localparam aluop_t EX_LW    = 5'd13;
    localparam aluop_t EX_LBU   = 5'd14;
    localparam aluop_t EX_LHU   = 5'd15;
    localparam aluop_t EX_SB    = 5'd16;
    localparam aluop_t EX_SH    = 5'd17;
    localparam aluop_t EX_SW    = 5'd18;
    localparam aluop_t EX_BEQ   = 5'd19;
    localparam aluop_t EX_BNE   = 5'd20;
    localparam aluop_t EX_BLT   = 5'd21;
    localparam aluop_t EX_BGE   = 5'd22;
    localparam aluop_t EX_BLTU  = 5'd23;
    localparam aluop_t EX_BGEU  = 5'd24;
    localparam aluop_t EX_JAL   = 5'd25;
    localparam aluop_t EX_JALR  = 5'd26;
    localparam aluop_t EX_AUIPC = 5'd27;

    // Result group, picks the EX result mux leg
    localparam alusel_t RES_NOP   = 3'd0;
    localparam alusel_t RES_ARITH = 3'd1;
    localparam alusel_t RES_LOGIC = 3'd2;
    localparam alusel_t RES_SHIFT = 3'd3;
    localparam alusel_t RES_LD_ST = 3'd4;
    localparam alusel_t RES_JUMP  = 3'd5;

    localparam imm_fmt_t IMM_NONE  = 3'd0;
    localparam imm_fmt_t IMM_I     = 3'd1;
    localparam imm_fmt_t IMM_SHAMT = 3'd2;
    localparam imm_fmt_t IMM_S     = 3'd3;
    localparam imm_fmt_t IMM_B     = 3'd4;
    localparam imm_fmt_t IMM_U     = 3'd5;
    localparam imm_fmt_t IMM_J     = 3'd6;

endpackage

`default_nettype wire

//--- source/inst_decoder.sv
`default_nettype none

module inst_decoder
    import rv_decode_pkg::*;
(
    input  wire inst_t inst,
    output logic       rs1_rd_en,
    output logic       rs2_rd_en,
    output logic       rd_en,
    output logic       use_imm,
    output aluop_t     aluop,
    output alusel_t    alusel,
    output imm_fmt_t   imm_fmt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        aluop     = EX_NOP;
        rs1_rd_en = 1'b0;
        rs2_rd_en = 1'b0;
        rd_en     = 1'b0;
        use_imm   = 1'b0;
        imm_fmt   = IMM_NONE;
        case (opcode)
            OP_REG: begin
                rs1_rd_en = 1'b1;
                rs2_rd_en = 1'b1;
                rd_en     = 1'b1;
                if (funct7 == FUNCT7_BASE) begin
                    case (funct3)
                        3'b000: aluop = EX_ADD;
                        3'b001: aluop = EX_SLL;
                        3'b010: aluop = EX_SLT;
                        3'b011: aluop = EX_SLTU;
                        3'b100: aluop = EX_XOR;
                        3'b101: aluop = EX_SRL;
                        3'b110: aluop = EX_OR;
                        3'b111: aluop = EX_AND;
                    endcase
                end else if (funct7 == FUNCT7_ALT) begin
                    case (funct3)
                        3'b000:  aluop = EX_SUB;
                        3'b101:  aluop = EX_SRA;
                        default: aluop = EX_NOP;
                    endcase
                end
            end
            OP_IMM: begin
                rs1_rd_en = 1'b1;
                rd_en     = 1'b1;
                use_imm   = 1'b1;
                imm_fmt   = IMM_I;
                case (funct3)
                    3'b000: aluop = EX_ADD;
                    3'b010: aluop = EX_SLT;
                    3'b011: aluop = EX_SLTU;
                    3'b100: aluop = EX_XOR;
                    3'b110: aluop = EX_OR;
                    3'b111: aluop = EX_AND;
                    3'b001: begin
                        imm_fmt = IMM_SHAMT;
                        if (funct7 == FUNCT7_BASE) aluop = EX_SLL;
                    end
                    3'b101: begin
                        imm_fmt = IMM_SHAMT;
                        if (funct7 == FUNCT7_BASE) aluop = EX_SRL;
                        else if (funct7 == FUNCT7_ALT) aluop = EX_SRA;
                    end
                endcase
            end
            OP_LUI: begin
                rd_en   = 1'b1;
                use_imm = 1'b1;
                imm_fmt = IMM_U;
                aluop   = EX_OR;  // rs1 reads as zero, so 0 | imm
            end
            OP_AUIPC: begin
                rd_en   = 1'b1;
                imm_fmt = IMM_U;
                aluop   = EX_AUIPC;
            end
            OP_LOAD: begin
                rs1_rd_en = 1'b1;
                rd_en     = 1'b1;
                imm_fmt   = IMM_I;
                case (funct3)
                    3'b000:  aluop = EX_LB;
                    3'b001:  aluop = EX_LH;
                    3'b010:  aluop = EX_LW;
                    3'b100:  aluop = EX_LBU;
                    3'b101:  aluop = EX_LHU;
                    default: aluop = EX_NOP;
                endcase
            end
            OP_STORE: begin
                rs1_rd_en = 1'b1;
                rs2_rd_en = 1'b1;
                imm_fmt   = IMM_S;
                case (funct3)
                    3'b000:  aluop = EX_SB;
                    3'b001:  aluop = EX_SH;
                    3'b010:  aluop = EX_SW;
                    default: aluop = EX_NOP;
                endcase
            end
            OP_BRANCH: begin
                rs1_rd_en = 1'b1;
                rs2_rd_en = 1'b1;
                imm_fmt   = IMM_B;
                case (funct3)
                    3'b000:  aluop = EX_BEQ;
                    3'b001:  aluop = EX_BNE;
                    3'b100:  aluop = EX_BLT;
                    3'b101:  aluop = EX_BGE;
                    3'b110:  aluop = EX_BLTU;
                    3'b111:  aluop = EX_BGEU;
                    default: aluop = EX_NOP;
                endcase
            end
            OP_JAL: begin
                rd_en   = 1'b1;
                imm_fmt = IMM_J;
                aluop   = EX_JAL;
            end
            OP_JALR: begin
                rs1_rd_en = 1'b1;
                rd_en     = 1'b1;
                imm_fmt   = IMM_I;
                if (funct3 == 3'b000) aluop = EX_JALR;
            end
            default: ;
        endcase

        // Anything left undecoded behaves as a bubble
        if (aluop == EX_NOP) begin
            rs1_rd_en = 1'b0;
            rs2_rd_en = 1'b0;
            rd_en     = 1'b0;
            use_imm   = 1'b0;
            imm_fmt   = IMM_NONE;
        end

        assert (!(rd_en && (aluop inside {EX_SB, EX_SH, EX_SW, EX_BEQ, EX_BNE,
                                          EX_BLT, EX_BGE, EX_BLTU, EX_BGEU})))
            else $error("inst_decoder: rd write enabled for store or branch");
    end

    always_comb begin
        case (aluop)
            EX_ADD, EX_SUB, EX_SLT, EX_SLTU, EX_AUIPC: alusel = RES_ARITH;
            EX_XOR, EX_OR, EX_AND:                     alusel = RES_LOGIC;
            EX_SLL, EX_SRL, EX_SRA:                    alusel = RES_SHIFT;
            EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU,
            EX_SB, EX_SH, EX_SW:                       alusel = RES_LD_ST;
            EX_JAL, EX_JALR:                           alusel = RES_JUMP;
            default:                                   alusel = RES_NOP;  // Branches too
        endcase
    end

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`default_nettype none

module imm_gen
    import rv_decode_pkg::*;
(
    input  wire inst_t    inst,
    input  wire imm_fmt_t imm_fmt,
    output xlen_t         imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            IMM_SHAMT: begin
                imm = {27'b0, inst[24:20]};  // Zero-extended shift amount
            end
            IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_U: begin
                // Full 20-bit upper field, for LUI and AUIPC alike
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/operand_fwd.sv
`default_nettype none

module operand_fwd
    import rv_decode_pkg::*;
(
    input  wire reg_addr_t src_addr,
    input  wire            rd_en,
    input  wire xlen_t     rf_data,
    input  wire            ex_load,
    input  wire            ex_wr_en,
    input  wire reg_addr_t ex_rd_addr,
    input  wire xlen_t     ex_result,
    input  wire            mem_wr_en,
    input  wire reg_addr_t mem_rd_addr,
    input  wire xlen_t     mem_result,
    output xlen_t          operand,
    output logic           hazard
);

    logic src_used;
    logic ex_match;
    logic mem_match;

    assign src_used  = rd_en && (src_addr != '0);  // x0 never forwards
    assign ex_match  = (ex_rd_addr == src_addr);
    assign mem_match = (mem_rd_addr == src_addr);

    always_comb begin
        operand = '0;
        hazard  = 1'b0;
        if (!src_used) begin
            operand = '0;
        end else if (ex_load && ex_match) begin
            hazard = 1'b1;  // Load data not ready until MEM
        end else if (ex_wr_en && ex_match) begin
            operand = ex_result;
        end else if (mem_wr_en && mem_match) begin
            operand = mem_result;
        end else begin
            operand = rf_data;
        end

        assert (!hazard || rd_en)
            else $error("operand_fwd: hazard raised for a source that is not read");
    end

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`default_nettype none

module id_ex_reg
    import rv_decode_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            in_valid,
    input  wire            stall,
    input  wire xlen_t     pc,
    input  wire xlen_t     r1,
    input  wire xlen_t     r2,
    input  wire xlen_t     imm,
    input  wire reg_addr_t rd,
    input  wire            rd_en,
    input  wire            use_imm,
    input  wire aluop_t    aluop,
    input  wire alusel_t   alusel,
    output logic           out_valid,
    output xlen_t          out_pc,
    output xlen_t          out_r1,
    output xlen_t          out_r2,
    output xlen_t          out_imm,
    output reg_addr_t      out_rd,
    output logic           out_rd_en,
    output logic           out_use_imm,
    output aluop_t         out_aluop,
    output alusel_t        out_alusel
);

    logic accept;

    assign accept = in_valid && !stall;

    // Control fields, a bubble when nothing is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_rd_en   <= 1'b0;
            out_use_imm <= 1'b0;
            out_aluop   <= EX_NOP;
            out_alusel  <= RES_NOP;
        end else begin
            out_valid   <= accept;
            out_rd_en   <= accept && rd_en;
            out_use_imm <= accept && use_imm;
            out_aluop   <= accept ? aluop : EX_NOP;
            out_alusel  <= accept ? alusel : RES_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_pc  <= '0;
            out_r1  <= '0;
            out_r2  <= '0;
            out_imm <= '0;
            out_rd  <= '0;
        end else if (accept) begin
            out_pc  <= pc;
            out_r1  <= r1;
            out_r2  <= r2;
            out_imm <= imm;
            out_rd  <= rd;
        end
    end

    a_stall_bubble: assert property (@(posedge clk) disable iff (rst) stall |=> !out_valid)
        else $error("id_ex_reg: instruction passed to EX on a stall cycle");

endmodule

`default_nettype wire

//--- source/id_stage.sv
`default_nettype none

module id_stage
    import rv_decode_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            in_valid,
    input  wire xlen_t     pc,
    input  wire inst_t     inst,
    input  wire xlen_t     rs1_data,
    input  wire xlen_t     rs2_data,
    input  wire            ex_load,
    input  wire            ex_wr_en,
    input  wire reg_addr_t ex_rd_addr,
    input  wire xlen_t     ex_result,
    input  wire            mem_wr_en,
    input  wire reg_addr_t mem_rd_addr,
    input  wire xlen_t     mem_result,
    output reg_addr_t      rs1_addr,
    output logic           rs1_rd_en,
    output reg_addr_t      rs2_addr,
    output logic           rs2_rd_en,
    output logic           stall,
    output logic           out_valid,
    output xlen_t          out_pc,
    output xlen_t          out_r1,
    output xlen_t          out_r2,
    output xlen_t          out_imm,
    output reg_addr_t      out_rd,
    output logic           out_rd_en,
    output logic           out_use_imm,
    output aluop_t         out_aluop,
    output alusel_t        out_alusel
);

    reg_addr_t rd_addr;
    logic      rd_en;
    logic      use_imm;
    aluop_t    aluop;
    alusel_t   alusel;
    imm_fmt_t  imm_fmt;
    xlen_t     imm;
    xlen_t     r1;
    xlen_t     r2;
    logic      rs1_hazard;
    logic      rs2_hazard;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];
    assign stall    = rs1_hazard | rs2_hazard;

    inst_decoder u_decoder (
        .inst      (inst),
        .rs1_rd_en (rs1_rd_en),
        .rs2_rd_en (rs2_rd_en),
        .rd_en     (rd_en),
        .use_imm   (use_imm),
        .aluop     (aluop),
        .alusel    (alusel),
        .imm_fmt   (imm_fmt)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    operand_fwd u_fwd_rs1 (
        .src_addr    (rs1_addr),
        .rd_en       (rs1_rd_en),
        .rf_data     (rs1_data),
        .ex_load     (ex_load),
        .ex_wr_en    (ex_wr_en),
        .ex_rd_addr  (ex_rd_addr),
        .ex_result   (ex_result),
        .mem_wr_en   (mem_wr_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_result  (mem_result),
        .operand     (r1),
        .hazard      (rs1_hazard)
    );

    operand_fwd u_fwd_rs2 (
        .src_addr    (rs2_addr),
        .rd_en       (rs2_rd_en),
        .rf_data     (rs2_data),
        .ex_load     (ex_load),
        .ex_wr_en    (ex_wr_en),
        .ex_rd_addr  (ex_rd_addr),
        .ex_result   (ex_result),
        .mem_wr_en   (mem_wr_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_result  (mem_result),
        .operand     (r2),
        .hazard      (rs2_hazard)
    );

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .stall       (stall),
        .pc          (pc),
        .r1          (r1),
        .r2          (r2),
        .imm         (imm),
        .rd          (rd_addr),
        .rd_en       (rd_en),
        .use_imm     (use_imm),
        .aluop       (aluop),
        .alusel      (alusel),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_r1      (out_r1),
        .out_r2      (out_r2),
        .out_imm     (out_imm),
        .out_rd      (out_rd),
        .out_rd_en   (out_rd_en),
        .out_use_imm (out_use_imm),
        .out_aluop   (out_aluop),
        .out_alusel  (out_alusel)
    );

endmodule

`default_nettype wire

//--- testbench/id_checker.sv
`default_nettype none

module id_checker
    import rv_decode_pkg::*;
(
    input wire reg_addr_t rs1_addr,
    input wire            rs1_rd_en,
    input wire reg_addr_t rs2_addr,
    input wire            rs2_rd_en,
    input wire            stall,
    input wire            out_valid,
    input wire xlen_t     out_pc,
    input wire xlen_t     out_r1,
    input wire xlen_t     out_r2,
    input wire xlen_t     out_imm,
    input wire reg_addr_t out_rd,
    input wire            out_rd_en,
    input wire            out_use_imm,
    input wire aluop_t    out_aluop,
    input wire alusel_t   out_alusel
);

    int pass_count = 0;
    int fail_count = 0;
    int mismatches = 0;  // Within the test in progress

    task automatic compare_field(input string test, input string field,
                                 input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h, actual %h", test, field, expected, actual);
            mismatches++;
        end
    endtask

    // Sampled in the cycle the instruction is presented
    task automatic check_comb_outputs(input string test, input logic exp_stall,
                                      input logic exp_rs1_en, input reg_addr_t exp_rs1,
                                      input logic exp_rs2_en, input reg_addr_t exp_rs2);
        compare_field(test, "stall", 32'(exp_stall), 32'(stall));
        compare_field(test, "rs1_rd_en", 32'(exp_rs1_en), 32'(rs1_rd_en));
        compare_field(test, "rs2_rd_en", 32'(exp_rs2_en), 32'(rs2_rd_en));
        if (exp_rs1_en) begin
            compare_field(test, "rs1_addr", 32'(exp_rs1), 32'(rs1_addr));
        end
        if (exp_rs2_en) begin
            compare_field(test, "rs2_addr", 32'(exp_rs2), 32'(rs2_addr));
        end
    endtask

    // Sampled one cycle after the instruction was presented
    task automatic check_outputs(input string test, input logic exp_valid,
                                 input logic exp_rd_en, input logic exp_use_imm,
                                 input aluop_t exp_aluop, input alusel_t exp_alusel,
                                 input xlen_t exp_pc, input xlen_t exp_r1,
                                 input xlen_t exp_r2, input xlen_t exp_imm,
                                 input reg_addr_t exp_rd);
        compare_field(test, "out_valid", 32'(exp_valid), 32'(out_valid));
        compare_field(test, "out_rd_en", 32'(exp_rd_en), 32'(out_rd_en));
        compare_field(test, "out_aluop", 32'(exp_aluop), 32'(out_aluop));
        if (exp_valid) begin  // Bubbles carry no data
            compare_field(test, "out_use_imm", 32'(exp_use_imm), 32'(out_use_imm));
            compare_field(test, "out_alusel", 32'(exp_alusel), 32'(out_alusel));
            compare_field(test, "out_pc", exp_pc, out_pc);
            compare_field(test, "out_r1", exp_r1, out_r1);
            compare_field(test, "out_r2", exp_r2, out_r2);
            compare_field(test, "out_imm", exp_imm, out_imm);
            if (exp_rd_en) begin
                compare_field(test, "out_rd", 32'(exp_rd), 32'(out_rd));
            end
        end
        if (mismatches == 0) begin
            pass_count++;
            $display("test %s: ok", test);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d mismatches", test, mismatches);
        end
        mismatches = 0;
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

endmodule

`default_nettype wire

//--- testbench/tb_id_stage.sv
`default_nettype none

module tb_id_stage
    import rv_decode_pkg::*;
();

    localparam int    NUM_TESTS  = 25;
    localparam int    CLK_PERIOD = 4;
    localparam xlen_t RS1_VAL    = 32'h1111_1111;
    localparam xlen_t RS2_VAL    = 32'h2222_2222;

    typedef struct {
        string     name;
        inst_t     inst;
        logic      ex_load;
        logic      ex_wr_en;
        reg_addr_t ex_rd;
        xlen_t     ex_res;
        logic      mem_wr_en;
        reg_addr_t mem_rd;
        xlen_t     mem_res;
        logic      exp_stall;
        logic      exp_rs1_en;
        logic      exp_rs2_en;
        reg_addr_t exp_rs1_addr;
        logic      exp_rd_en;
        logic      exp_use_imm;
        aluop_t    exp_aluop;
        alusel_t   exp_alusel;
        xlen_t     exp_r1;
        xlen_t     exp_r2;
        xlen_t     exp_imm;
    } test_entry_t;

    logic clk;
    logic rst;
    logic in_valid;
    xlen_t pc;
    inst_t inst;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic ex_load;
    logic ex_wr_en;
    reg_addr_t ex_rd_addr;
    xlen_t ex_result;
    logic mem_wr_en;
    reg_addr_t mem_rd_addr;
    xlen_t mem_result;
    reg_addr_t rs1_addr;
    logic rs1_rd_en;
    reg_addr_t rs2_addr;
    logic rs2_rd_en;
    logic stall;
    logic out_valid;
    xlen_t out_pc;
    xlen_t out_r1;
    xlen_t out_r2;
    xlen_t out_imm;
    reg_addr_t out_rd;
    logic out_rd_en;
    logic out_use_imm;
    aluop_t out_aluop;
    alusel_t out_alusel;

    test_entry_t tests [NUM_TESTS];
    int          n_tests = 0;

    id_stage u_id_stage (.*);
    id_checker u_checker (.*);

    // Encoders, all with rs1 = x5 (unless given), rs2 = x6, rd = x7
    function automatic inst_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rs1);
        return {f7, 5'd6, rs1, f3, 5'd7, OP_REG};
    endfunction

    function automatic inst_t i_type(logic [11:0] imm, logic [2:0] f3, logic [6:0] opcode);
        return {imm, 5'd5, f3, 5'd7, opcode};
    endfunction

    function automatic inst_t s_type(logic [11:0] imm);
        return {imm[11:5], 5'd6, 5'd5, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t b_type(logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd6, 5'd5, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic inst_t j_type(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd7, OP_JAL};
    endfunction

    function automatic inst_t u_type(logic [19:0] imm, logic [6:0] opcode);
        return {imm, 5'd7, opcode};
    endfunction

    task automatic add_test(input string name, input inst_t code, input aluop_t op,
                            input alusel_t sel, input logic rd_en, input logic use_imm,
                            input xlen_t imm, input xlen_t r1, input xlen_t r2,
                            input logic rs1_en, input logic rs2_en);
        tests[n_tests].name         = name;
        tests[n_tests].inst         = code;
        tests[n_tests].ex_load      = 1'b0;
        tests[n_tests].ex_wr_en     = 1'b0;
        tests[n_tests].ex_rd        = 5'd0;
        tests[n_tests].ex_res       = 32'h0;
        tests[n_tests].mem_wr_en    = 1'b0;
        tests[n_tests].mem_rd       = 5'd0;
        tests[n_tests].mem_res      = 32'h0;
        tests[n_tests].exp_stall    = 1'b0;
        tests[n_tests].exp_rs1_en   = rs1_en;
        tests[n_tests].exp_rs2_en   = rs2_en;
        tests[n_tests].exp_rs1_addr = 5'd5;
        tests[n_tests].exp_rd_en    = rd_en;
        tests[n_tests].exp_use_imm  = use_imm;
        tests[n_tests].exp_aluop    = op;
        tests[n_tests].exp_alusel   = sel;
        tests[n_tests].exp_r1       = r1;
        tests[n_tests].exp_r2       = r2;
        tests[n_tests].exp_imm      = imm;
        n_tests++;
    endtask

    // Forward inputs for the last entry added
    task automatic set_fwd(input logic ld, input logic ex_wr, input reg_addr_t ex_rd,
                           input xlen_t ex_res, input logic mem_wr, input reg_addr_t mem_rd,
                           input xlen_t mem_res, input logic exp_stall);
        tests[n_tests-1].ex_load   = ld;
        tests[n_tests-1].ex_wr_en  = ex_wr;
        tests[n_tests-1].ex_rd     = ex_rd;
        tests[n_tests-1].ex_res    = ex_res;
        tests[n_tests-1].mem_wr_en = mem_wr;
        tests[n_tests-1].mem_rd    = mem_rd;
        tests[n_tests-1].mem_res   = mem_res;
        tests[n_tests-1].exp_stall = exp_stall;
    endtask

    task automatic build_table();
        inst_t add_x5_x6;
        add_x5_x6 = r_type(FUNCT7_BASE, 3'b000, 5'd5);
        add_test("add", add_x5_x6, EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("sub", r_type(FUNCT7_ALT, 3'b000, 5'd5), EX_SUB, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("xor", r_type(FUNCT7_BASE, 3'b100, 5'd5), EX_XOR, RES_LOGIC,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("or", r_type(FUNCT7_BASE, 3'b110, 5'd5), EX_OR, RES_LOGIC,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("and", r_type(FUNCT7_BASE, 3'b111, 5'd5), EX_AND, RES_LOGIC,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("sll", r_type(FUNCT7_BASE, 3'b001, 5'd5), EX_SLL, RES_SHIFT,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("srl", r_type(FUNCT7_BASE, 3'b101, 5'd5), EX_SRL, RES_SHIFT,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("sra", r_type(FUNCT7_ALT, 3'b101, 5'd5), EX_SRA, RES_SHIFT,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("slt", r_type(FUNCT7_BASE, 3'b010, 5'd5), EX_SLT, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("sltu", r_type(FUNCT7_BASE, 3'b011, 5'd5), EX_SLTU, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("addi_neg", i_type(12'hffb, 3'b000, OP_IMM), EX_ADD, RES_ARITH,
                 1'b1, 1'b1, 32'hffff_fffb, RS1_VAL, 32'h0, 1'b1, 1'b0);
        add_test("srai", i_type({FUNCT7_ALT, 5'd3}, 3'b101, OP_IMM), EX_SRA, RES_SHIFT,
                 1'b1, 1'b1, 32'h0000_0003, RS1_VAL, 32'h0, 1'b1, 1'b0);
        add_test("lw_neg", i_type(12'hffc, 3'b010, OP_LOAD), EX_LW, RES_LD_ST,
                 1'b1, 1'b0, 32'hffff_fffc, RS1_VAL, 32'h0, 1'b1, 1'b0);
        add_test("sw_neg", s_type(12'hff4), EX_SW, RES_LD_ST,
                 1'b0, 1'b0, 32'hffff_fff4, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("beq_neg", b_type(13'h1ff0), EX_BEQ, RES_NOP,
                 1'b0, 1'b0, 32'hffff_fff0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        add_test("jal_neg", j_type(21'h112abc), EX_JAL, RES_JUMP,
                 1'b1, 1'b0, 32'hfff1_2abc, 32'h0, 32'h0, 1'b0, 1'b0);
        add_test("lui", u_type(20'habcde, OP_LUI), EX_OR, RES_LOGIC,
                 1'b1, 1'b1, 32'habcd_e000, 32'h0, 32'h0, 1'b0, 1'b0);
        add_test("auipc", u_type(20'h80001, OP_AUIPC), EX_AUIPC, RES_ARITH,
                 1'b1, 1'b0, 32'h8000_1000, 32'h0, 32'h0, 1'b0, 1'b0);
        add_test("fwd_ex_over_mem", add_x5_x6, EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, 32'haaaa_0001, RS2_VAL, 1'b1, 1'b1);
        set_fwd(1'b0, 1'b1, 5'd5, 32'haaaa_0001, 1'b1, 5'd5, 32'hbbbb_0002, 1'b0);
        add_test("fwd_mem_only", add_x5_x6, EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, 32'hbbbb_0003, 1'b1, 1'b1);
        set_fwd(1'b0, 1'b1, 5'd9, 32'haaaa_0004, 1'b1, 5'd6, 32'hbbbb_0003, 1'b0);
        add_test("fwd_regfile", add_x5_x6, EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, RS1_VAL, RS2_VAL, 1'b1, 1'b1);
        set_fwd(1'b0, 1'b1, 5'd3, 32'haaaa_0005, 1'b1, 5'd4, 32'hbbbb_0005, 1'b0);
        add_test("src_x0", r_type(FUNCT7_BASE, 3'b000, 5'd0), EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, 32'h0, RS2_VAL, 1'b1, 1'b1);
        set_fwd(1'b1, 1'b1, 5'd0, 32'hdead_0006, 1'b1, 5'd0, 32'hdead_0007, 1'b0);
        tests[n_tests-1].exp_rs1_addr = 5'd0;
        add_test("load_use", add_x5_x6, EX_NOP, RES_NOP,
                 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1);
        set_fwd(1'b1, 1'b1, 5'd5, 32'hdead_0008, 1'b0, 5'd0, 32'h0, 1'b1);
        // Load has moved on to MEM
        add_test("load_use_retry", add_x5_x6, EX_ADD, RES_ARITH,
                 1'b1, 1'b0, 32'h0, 32'hcccc_0009, RS2_VAL, 1'b1, 1'b1);
        set_fwd(1'b0, 1'b0, 5'd0, 32'h0, 1'b1, 5'd5, 32'hcccc_0009, 1'b0);
        add_test("unknown_opcode", 32'hffff_ffff, EX_NOP, RES_NOP,
                 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic apply_entry(input int i);
        in_valid    <= 1'b1;
        pc          <= 32'h0000_1000 + i * 4;
        inst        <= tests[i].inst;
        rs1_data    <= RS1_VAL;
        rs2_data    <= RS2_VAL;
        ex_load     <= tests[i].ex_load;
        ex_wr_en    <= tests[i].ex_wr_en;
        ex_rd_addr  <= tests[i].ex_rd;
        ex_result   <= tests[i].ex_res;
        mem_wr_en   <= tests[i].mem_wr_en;
        mem_rd_addr <= tests[i].mem_rd;
        mem_result  <= tests[i].mem_res;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        pc          = '0;
        inst        = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        ex_load     = 1'b0;
        ex_wr_en    = 1'b0;
        ex_rd_addr  = '0;
        ex_result   = '0;
        mem_wr_en   = 1'b0;
        mem_rd_addr = '0;
        mem_result  = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        u_checker.check_outputs("after_reset", 1'b0, 1'b0, 1'b0, EX_NOP, RES_NOP,
                                32'h0, 32'h0, 32'h0, 32'h0, 5'd0);
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            apply_entry(i);
            @(negedge clk);
            u_checker.check_comb_outputs(tests[i].name, tests[i].exp_stall,
                                         tests[i].exp_rs1_en, tests[i].exp_rs1_addr,
                                         tests[i].exp_rs2_en, 5'd6);
            @(posedge clk);
            in_valid <= 1'b0;  // Idle cycle between tests
            @(negedge clk);
            u_checker.check_outputs(tests[i].name, !tests[i].exp_stall, tests[i].exp_rd_en,
                                    tests[i].exp_use_imm, tests[i].exp_aluop,
                                    tests[i].exp_alusel, 32'h0000_1000 + i * 4,
                                    tests[i].exp_r1, tests[i].exp_r2, tests[i].exp_imm, 5'd7);
        end
        u_checker.report();
        if (u_checker.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Four cycles allowed for each two-cycle test
    initial begin
        #((NUM_TESTS * 4 + 20) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
source/rv_decode_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/operand_fwd.sv
source/id_ex_reg.sv
source/id_stage.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_id_stage
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
